/* Makefile */
VERILATOR ?= verilator
FLIST     ?= flist.f
TB_TOP    ?= socket_tb
RTL_TOP   ?= socket_top
BUILD     ?= obj_dir
VFLAGS    ?= --timing -Wall

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

$(BUILD)/V$(TB_TOP): $(shell grep -v '^+' $(FLIST)) logic/socket_macros.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(BUILD)

sim: $(BUILD)/V$(TB_TOP)
	@out=$$(./$(BUILD)/V$(TB_TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD)

/* bench/socket_patterns.txt */
# cluster op addr data expected dram_reads, all hex
# op 0 read, 1 write, 2 halt (expected is top ebreak), 3 snoop (expected is tag), 4 pair read
0 0 0012 00000000 0012ffed 1
1 0 0012 00000000 0012ffed 0
0 0 0012 00000000 0012ffed 0
0 1 0034 cafef00d cafef00d 0
1 0 0034 00000000 cafef00d 1
0 0 0034 00000000 cafef00d 0
0 4 0056 00000000 0056ffa9 2
1 4 0056 00000000 0056ffa9 0
0 4 0098 00000000 0098ff67 2
0 3 0012 00000000 00000007 0
1 0 0012 00000000 0012ffed 1
1 1 0012 11223344 11223344 0
0 0 0012 00000000 11223344 0
1 3 00a1 00000000 0000000c 0
0 0 00a1 00000000 00a1ff5e 1
1 0 00a1 00000000 00a1ff5e 0
0 2 0000 00000000 00000000 0
1 2 0000 00000000 00000001 0

/* bench/socket_tb.sv */
`include "socket_macros.svh"

module socket_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                                     clk;
    logic                                     arst_n;
    logic [`NUM_CLUSTERS-1:0]                 cmd_valid;
    socket_pkg::cmd_t [`NUM_CLUSTERS-1:0]     cmd;
    logic [`NUM_CLUSTERS-1:0]                 cmd_ready;
    logic [`NUM_CLUSTERS-1:0]                 rsp_valid;
    logic [`NUM_CLUSTERS-1:0][`LINE_BITS-1:0] rsp_data;
    logic                                     dram_req_valid;
    socket_pkg::mem_req_t                     dram_req;
    logic                                     dram_req_ready;
    logic                                     dram_rsp_valid;
    socket_pkg::mem_rsp_t                     dram_rsp;
    logic                                     dram_rsp_ready;
    logic                                     snp_req_valid;
    socket_pkg::snp_req_t                     snp_req;
    logic                                     snp_req_ready;
    logic                                     snp_rsp_valid;
    logic [`SNP_TAG_BITS-1:0]                 snp_rsp_tag;
    logic                                     snp_rsp_ready;
    logic                                     busy;
    logic                                     ebreak;

    // DRAM model state
    logic [`LINE_BITS-1:0] mem [logic [`LINE_ADDR_BITS-1:0]];
    int unsigned           rd_count;
    int unsigned           wr_count;
    logic [`LINE_ADDR_BITS-1:0] last_rd_addr;
    logic [`LINE_ADDR_BITS-1:0] last_wr_addr;
    logic [`LINE_BITS-1:0]      last_wr_data;
    logic                  req_seen;
    logic                  rsp_taken;
    socket_pkg::mem_req_t  req_cap;
    logic                  rd_pending;
    int unsigned           rd_delay;
    socket_pkg::mem_req_t  rd_req;
    logic [31:0]           rng;

    // Patterns
    logic [31:0] pat_cl [$];
    logic [31:0] pat_op [$];
    logic [31:0] pat_addr [$];
    logic [31:0] pat_data [$];
    logic [31:0] pat_exp [$];
    logic [31:0] pat_ndram [$];
    logic        loaded;
    int          errors;

    logic [`LINE_BITS-1:0] got_data [`NUM_CLUSTERS];

    socket_top socket_top_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .cmd_valid      (cmd_valid),
        .cmd            (cmd),
        .cmd_ready      (cmd_ready),
        .rsp_valid      (rsp_valid),
        .rsp_data       (rsp_data),
        .dram_req_valid (dram_req_valid),
        .dram_req       (dram_req),
        .dram_req_ready (dram_req_ready),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp       (dram_rsp),
        .dram_rsp_ready (dram_rsp_ready),
        .snp_req_valid  (snp_req_valid),
        .snp_req        (snp_req),
        .snp_req_ready  (snp_req_ready),
        .snp_rsp_valid  (snp_rsp_valid),
        .snp_rsp_tag    (snp_rsp_tag),
        .snp_rsp_ready  (snp_rsp_ready),
        .busy           (busy),
        .ebreak         (ebreak)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Untouched DRAM words depend on every address bit
    function automatic logic [`LINE_BITS-1:0] fill_word(input logic [`LINE_ADDR_BITS-1:0] a);
        return {a, ~a};
    endfunction

    function automatic logic [`LINE_BITS-1:0] model_word(input logic [`LINE_ADDR_BITS-1:0] a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_word(a);
    endfunction

    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
    endtask

    // Sample where stable, act on the following rising edge
    always @(negedge clk) begin
        req_seen  = dram_req_valid && dram_req_ready;
        req_cap   = dram_req;
        rsp_taken = dram_rsp_valid && dram_rsp_ready;
    end

    always @(posedge clk) begin
        if (arst_n) begin
            if (req_seen) begin
                if (req_cap.write) begin
                    mem[req_cap.addr] = req_cap.data;
                    wr_count++;
                    last_wr_addr = req_cap.addr;
                    last_wr_data = req_cap.data;
                end else begin
                    rd_count++;
                    last_rd_addr = req_cap.addr;
                    rd_req     = req_cap;
                    rng        = xorshift(rng);
                    rd_delay   = rng % 5;
                    rd_pending = 1'b1;
                end
                req_seen = 1'b0;
            end
            if (rsp_taken) begin
                dram_rsp_valid <= 1'b0;
                rsp_taken = 1'b0;
            end else if (rd_pending) begin
                if (rd_delay == 0) begin
                    dram_rsp_valid <= 1'b1;
                    dram_rsp.data  <= model_word(rd_req.addr);
                    dram_rsp.tag   <= rd_req.tag;
                    rd_pending = 1'b0;
                end else begin
                    rd_delay--;
                end
            end
            rng = xorshift(rng);
            dram_req_ready <= rng[7];
        end
    end

    // Drives the clusters in mask until accepted and, where wanted, answered
    task automatic serve(input logic [`NUM_CLUSTERS-1:0] mask,
                         input logic [`NUM_CLUSTERS-1:0] want_rsp);
        logic [`NUM_CLUSTERS-1:0] pend_acc;
        logic [`NUM_CLUSTERS-1:0] take;
        logic [`NUM_CLUSTERS-1:0] got;
        pend_acc = mask;
        got      = mask & ~want_rsp;
        do begin
            @(negedge clk);
            for (int i = 0; i < `NUM_CLUSTERS; i++) begin
                take[i] = pend_acc[i] && cmd_ready[i];
                if (mask[i] && !pend_acc[i] && !got[i]) begin
                    if (rsp_valid[i]) begin
                        got[i]      = 1'b1;
                        got_data[i] = rsp_data[i];
                    end else begin
                        check(32'(busy), 32'd1, "busy low while a request is outstanding");
                    end
                end
            end
            @(posedge clk);
            for (int i = 0; i < `NUM_CLUSTERS; i++) begin
                if (take[i]) begin
                    cmd_valid[i] <= 1'b0;
                    pend_acc[i] = 1'b0;
                end
            end
        end while (pend_acc != '0 || got != mask);
    endtask

    task automatic drive_cmd(input int c, input socket_pkg::cmd_op_t op,
                             input logic [31:0] addr, input logic [31:0] data);
        cmd_valid[c]   <= 1'b1;
        cmd[c].op      <= op;
        cmd[c].addr    <= addr[`LINE_ADDR_BITS-1:0];
        cmd[c].data    <= data;
    endtask

    task automatic run_snoop(input logic [31:0] addr, input logic [31:0] tag);
        @(posedge clk);
        snp_req_valid <= 1'b1;
        snp_req.addr  <= addr[`LINE_ADDR_BITS-1:0];
        snp_req.tag   <= tag[`SNP_TAG_BITS-1:0];
        do @(negedge clk); while (!snp_req_ready);
        @(posedge clk);
        snp_req_valid <= 1'b0;
        do @(negedge clk); while (!snp_rsp_valid);
        check(32'(snp_rsp_tag), tag, "snoop response tag");
        // Held response must survive a cycle of back-pressure
        @(posedge clk);
        snp_rsp_ready <= 1'b1;
        @(negedge clk);
        check(32'(snp_rsp_valid), 32'd1, "snoop response dropped under back-pressure");
        @(posedge clk);
        snp_rsp_ready <= 1'b0;
        @(negedge clk);
        check(32'(snp_rsp_valid), 32'd0, "snoop response still valid after handshake");
    endtask

    task automatic load_patterns();
        int    fd;
        int    n;
        string line;
        logic [31:0] f [6];
        fd = $fopen("bench/socket_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open the pattern file bench/socket_patterns.txt");
            $display("TESTBENCH FAILED");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
            if (n == 6) begin
                pat_cl.push_back(f[0]);
                pat_op.push_back(f[1]);
                pat_addr.push_back(f[2]);
                pat_data.push_back(f[3]);
                pat_exp.push_back(f[4]);
                pat_ndram.push_back(f[5]);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        loaded = 1'b0;
        wait (loaded);
        repeat (pat_op.size() * 200) @(posedge clk);
        $display("Timeout: the tests did not finish in the allowed number of cycles");
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    initial begin
        int unsigned rd0;
        int unsigned wr0;
        int          c;
        logic [31:0] a;
        cmd_valid      = '0;
        cmd            = '0;
        dram_req_ready = 1'b0;
        dram_rsp_valid = 1'b0;
        dram_rsp       = '0;
        snp_req_valid  = 1'b0;
        snp_req        = '0;
        snp_rsp_ready  = 1'b0;
        arst_n         = 1'b0;
        rd_count       = 0;
        wr_count       = 0;
        rd_pending     = 1'b0;
        req_seen       = 1'b0;
        rsp_taken      = 1'b0;
        rng            = 32'd6680;
        errors         = 0;
        load_patterns();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check(32'(busy), 32'd0, "busy after reset");
        check(32'(ebreak), 32'd0, "ebreak after reset");
        check(32'(rsp_valid), 32'd0, "rsp_valid after reset");
        check(32'(dram_req_valid), 32'd0, "dram_req_valid after reset");
        check(32'(snp_rsp_valid), 32'd0, "snp_rsp_valid after reset");
        check(32'(cmd_ready), 32'd0, "cmd_ready in the first cycle after reset");

        for (int p = 0; p < pat_op.size(); p++) begin
            rd0 = rd_count;
            wr0 = wr_count;
            c   = int'(pat_cl[p]);
            a   = pat_addr[p];
            @(posedge clk);
            case (pat_op[p])
                0: begin
                    drive_cmd(c, socket_pkg::CMD_READ, a, 0);
                    serve(`NUM_CLUSTERS'(1) << c, `NUM_CLUSTERS'(1) << c);
                    check(got_data[c], pat_exp[p], "read data");
                    check(got_data[c], model_word(a[15:0]), "read data against DRAM model");
                    if (rd_count != rd0) begin
                        check(32'(last_rd_addr), a, "DRAM read address");
                    end
                end
                1: begin
                    drive_cmd(c, socket_pkg::CMD_WRITE, a, pat_data[p]);
                    serve(`NUM_CLUSTERS'(1) << c, `NUM_CLUSTERS'(1) << c);
                    check(got_data[c], pat_exp[p], "write echo");
                    check(wr_count - wr0, 1, "DRAM writes per write");
                    check(32'(last_wr_addr), a, "DRAM write address");
                    check(last_wr_data, pat_data[p], "DRAM write data");
                end
                2: begin
                    drive_cmd(c, socket_pkg::CMD_HALT, a, 0);
                    serve(`NUM_CLUSTERS'(1) << c, '0);
                    @(negedge clk);
                    check(32'(ebreak), pat_exp[p], "top-level ebreak after halt");
                end
                3: begin
                    run_snoop(a, pat_exp[p]);
                end
                default: begin
                    drive_cmd(0, socket_pkg::CMD_READ, a, 0);
                    drive_cmd(1, socket_pkg::CMD_READ, a + 1, 0);
                    serve('1, '1);
                    check(got_data[0], pat_exp[p], "pair read on cluster 0");
                    check(got_data[0], model_word(a[15:0]), "cluster 0 data against model");
                    check(got_data[1], model_word(a[15:0] + 16'd1), "cluster 1 data");
                end
            endcase
            check(rd_count - rd0, pat_ndram[p], $sformatf("DRAM reads for pattern %0d", p));
            if (pat_op[p] != 1) begin
                check(wr_count - wr0, 0, "unexpected DRAM write");
            end
        end

        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+logic
logic/socket_pkg.sv
logic/cluster_port.sv
logic/req_arbiter.sv
logic/l3_cache.sv
logic/socket_top.sv
bench/socket_tb.sv

/* logic/cluster_port.sv */
`include "socket_macros.svh"

module cluster_port #(
    parameter int CLUSTER_ID = 0
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cmd_valid,
    input  socket_pkg::cmd_t      cmd,
    output logic                  cmd_ready,
    output logic                  req_valid,
    output socket_pkg::mem_req_t  req,
    input  logic                  grant,
    input  logic                  core_rsp_valid,
    input  socket_pkg::mem_rsp_t  core_rsp,
    output logic                  rsp_valid,
    output logic [`LINE_BITS-1:0] rsp_data,
    input  logic                  fwd_valid,
    output logic                  fwd_ack,
    output logic                  busy,
    output logic                  ebreak
);
    localparam logic [`CL_ID_BITS-1:0] MY_ID = `CL_ID_BITS'(CLUSTER_ID);

    logic                 ready_q;
    logic                 req_valid_q;
    logic                 wait_q;
    logic                 ebreak_q;
    logic                 ack_q;
    logic                 cmd_acc;
    socket_pkg::mem_req_t req_q;

    // Held low for the first cycle out of reset
    assign cmd_ready = ready_q && !req_valid_q && !wait_q;
    assign cmd_acc   = cmd_valid && cmd_ready;

    assign req_valid = req_valid_q;
    assign req       = req_q;

    // Keep only responses that carry our own tag
    assign rsp_valid = wait_q && core_rsp_valid && (core_rsp.tag == MY_ID);
    assign rsp_data  = core_rsp.data;

    assign fwd_ack = ack_q;
    assign busy    = req_valid_q || wait_q;
    assign ebreak  = ebreak_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready_q     <= 1'b0;
            req_valid_q <= 1'b0;
            wait_q      <= 1'b0;
            ebreak_q    <= 1'b0;
            ack_q       <= 1'b0;
        end else begin
            ready_q <= 1'b1;
            ack_q   <= fwd_valid && !ack_q;
            if (cmd_acc) begin
                if (cmd.op == socket_pkg::CMD_HALT) begin
                    ebreak_q <= 1'b1;
                end else begin
                    req_valid_q <= 1'b1;
                end
            end
            if (req_valid_q && grant) begin
                req_valid_q <= 1'b0;
                wait_q      <= 1'b1;
            end
            if (rsp_valid) begin
                wait_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_acc) begin
            req_q.write <= (cmd.op == socket_pkg::CMD_WRITE);
            req_q.addr  <= cmd.addr;
            req_q.data  <= cmd.data;
            req_q.tag   <= MY_ID;
        end
    end

endmodule

/* logic/l3_cache.sv */
`include "socket_macros.svh"

module l3_cache (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       core_req_valid,
    input  socket_pkg::mem_req_t       core_req,
    output logic                       core_req_ready,
    output logic                       core_rsp_valid,
    output socket_pkg::mem_rsp_t       core_rsp,
    output logic                       dram_req_valid,
    output socket_pkg::mem_req_t       dram_req,
    input  logic                       dram_req_ready,
    input  logic                       dram_rsp_valid,
    input  socket_pkg::mem_rsp_t       dram_rsp,
    output logic                       dram_rsp_ready,
    input  logic                       snp_req_valid,
    input  socket_pkg::snp_req_t       snp_req,
    output logic                       snp_req_ready,
    output logic                       snp_rsp_valid,
    output logic [`SNP_TAG_BITS-1:0]   snp_rsp_tag,
    input  logic                       snp_rsp_ready,
    output logic [`NUM_CLUSTERS-1:0]   fwd_valid,
    output logic [`LINE_ADDR_BITS-1:0] fwd_addr,
    input  logic [`NUM_CLUSTERS-1:0]   fwd_ack,
    output logic                       busy
);
    localparam int IDX_BITS = $clog2(`L3_LINES);
    localparam int TAG_BITS = `LINE_ADDR_BITS - IDX_BITS;

    typedef enum logic [2:0] {S_IDLE, S_MISS, S_WRITE, S_SNP_FWD, S_SNP_RSP} state_t;

    state_t                   state_q;
    logic [`L3_LINES-1:0]     valid_q;
    logic [TAG_BITS-1:0]      tag_mem  [`L3_LINES];
    logic [`LINE_BITS-1:0]    data_mem [`L3_LINES];
    logic                     lk_valid_q;
    socket_pkg::mem_req_t     lk_req_q;
    logic                     rsp_valid_q;
    socket_pkg::mem_rsp_t     rsp_q;
    socket_pkg::mem_req_t     pend_q;
    logic                     sent_q;
    socket_pkg::snp_req_t     snp_q;
    logic [`NUM_CLUSTERS-1:0] ack_mask_q;

    logic [IDX_BITS-1:0]      lk_idx;
    logic                     lk_hit_read;
    logic                     lk_to_fsm;
    logic [IDX_BITS-1:0]      pend_idx;
    logic [TAG_BITS-1:0]      pend_tag;
    logic                     pend_hit;
    logic [IDX_BITS-1:0]      snp_idx;
    logic                     snp_hit;
    logic                     core_acc;
    logic                     snp_acc;
    logic                     dram_acc;
    logic                     fill;
    logic [`NUM_CLUSTERS-1:0] ack_next;

    // Lookup stage
    assign lk_idx      = lk_req_q.addr[IDX_BITS-1:0];
    assign lk_hit_read = lk_valid_q && !lk_req_q.write && valid_q[lk_idx]
                         && (tag_mem[lk_idx] == lk_req_q.addr[`LINE_ADDR_BITS-1:IDX_BITS]);
    // Misses and writes leave the pipeline for the FSM
    assign lk_to_fsm   = lk_valid_q && !lk_hit_read;

    assign pend_idx = pend_q.addr[IDX_BITS-1:0];
    assign pend_tag = pend_q.addr[`LINE_ADDR_BITS-1:IDX_BITS];
    assign pend_hit = valid_q[pend_idx] && (tag_mem[pend_idx] == pend_tag);

    assign snp_idx = snp_req.addr[IDX_BITS-1:0];
    assign snp_hit = valid_q[snp_idx]
                     && (tag_mem[snp_idx] == snp_req.addr[`LINE_ADDR_BITS-1:IDX_BITS]);

    // Snoop wins over a core request in the same cycle
    assign snp_req_ready  = (state_q == S_IDLE) && !lk_to_fsm;
    assign core_req_ready = snp_req_ready && !snp_req_valid;
    assign core_acc       = core_req_valid && core_req_ready;
    assign snp_acc        = snp_req_valid && snp_req_ready;

    assign dram_req_valid = ((state_q == S_MISS) || (state_q == S_WRITE)) && !sent_q;
    assign dram_req       = pend_q;
    assign dram_acc       = dram_req_valid && dram_req_ready;
    assign dram_rsp_ready = (state_q == S_MISS) && sent_q;
    assign fill           = dram_rsp_valid && dram_rsp_ready;

    assign ack_next      = ack_mask_q | fwd_ack;
    assign fwd_valid     = (state_q == S_SNP_FWD) ? ~ack_mask_q : '0;
    assign fwd_addr      = snp_q.addr;
    assign snp_rsp_valid = (state_q == S_SNP_RSP);
    assign snp_rsp_tag   = snp_q.tag;

    assign core_rsp_valid = rsp_valid_q;
    assign core_rsp       = rsp_q;
    assign busy           = (state_q != S_IDLE) || lk_valid_q || rsp_valid_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= S_IDLE;
            valid_q     <= '0;
            lk_valid_q  <= 1'b0;
            rsp_valid_q <= 1'b0;
            sent_q      <= 1'b0;
            ack_mask_q  <= '0;
        end else begin
            lk_valid_q  <= core_acc;
            rsp_valid_q <= lk_hit_read;
            case (state_q)
                S_IDLE: begin
                    if (lk_to_fsm) begin
                        state_q <= lk_req_q.write ? S_WRITE : S_MISS;
                        sent_q  <= 1'b0;
                    end else if (snp_acc) begin
                        state_q    <= S_SNP_FWD;
                        ack_mask_q <= '0;
                        if (snp_hit) begin
                            valid_q[snp_idx] <= 1'b0;
                        end
                    end
                end
                S_MISS: begin
                    if (dram_acc) begin
                        sent_q <= 1'b1;
                    end
                    if (fill) begin
                        valid_q[pend_idx] <= 1'b1;
                        rsp_valid_q       <= 1'b1;
                        state_q           <= S_IDLE;
                    end
                end
                S_WRITE: begin
                    if (dram_acc) begin
                        rsp_valid_q <= 1'b1;
                        state_q     <= S_IDLE;
                    end
                end
                S_SNP_FWD: begin
                    ack_mask_q <= ack_next;
                    if (&ack_next) begin
                        state_q <= S_SNP_RSP;
                    end
                end
                S_SNP_RSP: begin
                    if (snp_rsp_ready) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (core_acc) begin
            lk_req_q <= core_req;
        end
        if (lk_hit_read) begin
            rsp_q.data <= data_mem[lk_idx];
            rsp_q.tag  <= lk_req_q.tag;
        end
        if ((state_q == S_IDLE) && lk_to_fsm) begin
            pend_q <= lk_req_q;
        end
        if (snp_acc) begin
            snp_q <= snp_req;
        end
        if (fill) begin
            tag_mem[pend_idx]  <= pend_tag;
            data_mem[pend_idx] <= dram_rsp.data;
            rsp_q.data         <= dram_rsp.data;
            rsp_q.tag          <= dram_rsp.tag;
        end
        // Write-through updates the line only on a hit
        if ((state_q == S_WRITE) && dram_acc) begin
            if (pend_hit) begin
                data_mem[pend_idx] <= pend_q.data;
            end
            rsp_q.data <= pend_q.data;
            rsp_q.tag  <= pend_q.tag;
        end
    end

endmodule

/* logic/req_arbiter.sv */
module req_arbiter #(
    parameter type T_PAYLOAD = socket_pkg::mem_req_t,
    parameter int  N         = 2
) (
    input  logic         clk,
    input  logic         arst_n,
    input  logic [N-1:0] req_valid,
    input  T_PAYLOAD     req [N],
    output logic [N-1:0] grant,
    output logic         out_valid,
    output T_PAYLOAD     out_req,
    input  logic         out_ready
);
    localparam int PTR_BITS = (N > 1) ? $clog2(N) : 1;

    logic [PTR_BITS-1:0] last_q;
    logic [PTR_BITS-1:0] hold_idx_q;
    logic                hold_q;
    logic [PTR_BITS-1:0] pick;
    logic [PTR_BITS-1:0] win;
    logic                found;

    // First requester after the last winner
    always_comb begin
        int unsigned idx;
        found = 1'b0;
        pick  = last_q;
        for (int k = 1; k <= N; k++) begin
            idx = (int'(last_q) + k) % N;
            if (!found && req_valid[idx]) begin
                found = 1'b1;
                pick  = PTR_BITS'(idx);
            end
        end
    end

    // A stalled winner keeps the bus until taken
    assign win       = hold_q ? hold_idx_q : pick;
    assign out_valid = hold_q || found;
    assign out_req   = req[win];
    assign grant     = (out_valid && out_ready) ? (N'(1) << win) : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_q     <= PTR_BITS'(N - 1);
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else if (out_valid && out_ready) begin
            last_q <= win;
            hold_q <= 1'b0;
        end else if (out_valid) begin
            hold_q     <= 1'b1;
            hold_idx_q <= win;
        end
    end

endmodule

/* logic/socket_macros.svh */
`ifndef SOCKET_MACROS_SVH
`define SOCKET_MACROS_SVH

// Clusters sharing the last-level cache
`define NUM_CLUSTERS 2

// Enough bits to tell every cluster apart
`define CL_ID_BITS 1

// Line address and line payload
`define LINE_ADDR_BITS 16
`define LINE_BITS 32

// Direct-mapped depth in lines as a power of two
`define L3_LINES 16

// Tag carried by an external snoop
`define SNP_TAG_BITS 4

`endif

/* logic/socket_pkg.sv */
`include "socket_macros.svh"

package socket_pkg;

    typedef enum logic [1:0] {
        CMD_READ  = 2'd0,
        CMD_WRITE = 2'd1,
        CMD_HALT  = 2'd2
    } cmd_op_t;

    // Command from the per-cluster port
    typedef struct packed {
        cmd_op_t                    op;
        logic [`LINE_ADDR_BITS-1:0] addr;
        logic [`LINE_BITS-1:0]      data;
    } cmd_t;

    // Cluster to cache and cache to DRAM
    typedef struct packed {
        logic                       write;
        logic [`LINE_ADDR_BITS-1:0] addr;
        logic [`LINE_BITS-1:0]      data;
        logic [`CL_ID_BITS-1:0]     tag;
    } mem_req_t;

    typedef struct packed {
        logic [`LINE_BITS-1:0]  data;
        logic [`CL_ID_BITS-1:0] tag;
    } mem_rsp_t;

    typedef struct packed {
        logic [`LINE_ADDR_BITS-1:0] addr;
        logic [`SNP_TAG_BITS-1:0]   tag;
    } snp_req_t;

endpackage

/* logic/socket_top.sv */
`include "socket_macros.svh"

module socket_top (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic [`NUM_CLUSTERS-1:0]                  cmd_valid,
    input  socket_pkg::cmd_t [`NUM_CLUSTERS-1:0]      cmd,
    output logic [`NUM_CLUSTERS-1:0]                  cmd_ready,
    output logic [`NUM_CLUSTERS-1:0]                  rsp_valid,
    output logic [`NUM_CLUSTERS-1:0][`LINE_BITS-1:0]  rsp_data,
    output logic                                      dram_req_valid,
    output socket_pkg::mem_req_t                      dram_req,
    input  logic                                      dram_req_ready,
    input  logic                                      dram_rsp_valid,
    input  socket_pkg::mem_rsp_t                      dram_rsp,
    output logic                                      dram_rsp_ready,
    input  logic                                      snp_req_valid,
    input  socket_pkg::snp_req_t                      snp_req,
    output logic                                      snp_req_ready,
    output logic                                      snp_rsp_valid,
    output logic [`SNP_TAG_BITS-1:0]                  snp_rsp_tag,
    input  logic                                      snp_rsp_ready,
    output logic                                      busy,
    output logic                                      ebreak
);
    logic [`NUM_CLUSTERS-1:0] cl_req_valid;
    socket_pkg::mem_req_t     cl_req [`NUM_CLUSTERS];
    logic [`NUM_CLUSTERS-1:0] cl_grant;
    logic [`NUM_CLUSTERS-1:0] cl_busy;
    logic [`NUM_CLUSTERS-1:0] cl_ebreak;
    logic                     arb_valid;
    socket_pkg::mem_req_t     arb_req;
    logic                     arb_ready;
    logic                     core_rsp_valid;
    socket_pkg::mem_rsp_t     core_rsp;
    logic [`NUM_CLUSTERS-1:0] fwd_valid;
    logic [`NUM_CLUSTERS-1:0] fwd_ack;
    logic                     l3_busy;

    for (genvar i = 0; i < `NUM_CLUSTERS; i++) begin : g_cluster
        cluster_port #(
            .CLUSTER_ID (i)
        ) cluster_port_inst (
            .clk            (clk),
            .arst_n         (arst_n),
            .cmd_valid      (cmd_valid[i]),
            .cmd            (cmd[i]),
            .cmd_ready      (cmd_ready[i]),
            .req_valid      (cl_req_valid[i]),
            .req            (cl_req[i]),
            .grant          (cl_grant[i]),
            .core_rsp_valid (core_rsp_valid),
            .core_rsp       (core_rsp),
            .rsp_valid      (rsp_valid[i]),
            .rsp_data       (rsp_data[i]),
            .fwd_valid      (fwd_valid[i]),
            .fwd_ack        (fwd_ack[i]),
            .busy           (cl_busy[i]),
            .ebreak         (cl_ebreak[i])
        );
    end

    req_arbiter #(
        .T_PAYLOAD (socket_pkg::mem_req_t),
        .N         (`NUM_CLUSTERS)
    ) req_arbiter_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (cl_req_valid),
        .req       (cl_req),
        .grant     (cl_grant),
        .out_valid (arb_valid),
        .out_req   (arb_req),
        .out_ready (arb_ready)
    );

    // Clusters keep no lines, so the forwarded address goes nowhere
    l3_cache l3_cache_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .core_req_valid (arb_valid),
        .core_req       (arb_req),
        .core_req_ready (arb_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .dram_req_valid (dram_req_valid),
        .dram_req       (dram_req),
        .dram_req_ready (dram_req_ready),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp       (dram_rsp),
        .dram_rsp_ready (dram_rsp_ready),
        .snp_req_valid  (snp_req_valid),
        .snp_req        (snp_req),
        .snp_req_ready  (snp_req_ready),
        .snp_rsp_valid  (snp_rsp_valid),
        .snp_rsp_tag    (snp_rsp_tag),
        .snp_rsp_ready  (snp_rsp_ready),
        .fwd_valid      (fwd_valid),
        .fwd_addr       (),
        .fwd_ack        (fwd_ack),
        .busy           (l3_busy)
    );

    assign busy   = (|cl_busy) || l3_busy;
    assign ebreak = &cl_ebreak;

endmodule
